//--- Makefile
# Verilator simulation of the memory request arbiter

VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := tb_memory_request_arbiter
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation PASSED

.PHONY: sim clean

# The run passes only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
rtl/memory_request_pkg.sv
rtl/sync_fifo.sv
rtl/round_robin_arbiter.sv
rtl/memory_request_arbiter.sv
tests/tb_memory_request_arbiter.sv

//--- rtl/memory_request_arbiter.sv
`timescale 1ns/1ns

module memory_request_arbiter (
  input  logic                                          ap_clk,
  input  logic                                          areset_control,
  input  logic [memory_request_pkg::NUM_REQUESTORS-1:0] request_in_valid,
  input  logic [memory_request_pkg::PAYLOAD_WIDTH-1:0]  request_in_payload
                                                          [memory_request_pkg::NUM_REQUESTORS],
  input  logic                                          pop_out,
  output logic [memory_request_pkg::NUM_REQUESTORS-1:0] requestor_ready,
  output logic                                          request_out_valid,
  output logic [memory_request_pkg::PAYLOAD_WIDTH-1:0]  request_out_payload,
  output logic                                          out_empty,
  output logic                                          out_prog_full,
  output logic                                          fifo_setup
);

  // ---------------------------------------
  // Local signals
  // ---------------------------------------

  // Registered reset copies
  logic reset_local;
  logic reset_fifo;
  logic reset_arbiter;

  // Input stage
  logic [memory_request_pkg::NUM_REQUESTORS-1:0] request_in_valid_reg;
  logic [memory_request_pkg::PAYLOAD_WIDTH-1:0]  request_in_payload_reg
                                                   [memory_request_pkg::NUM_REQUESTORS];

  // Input FIFO ports
  logic [memory_request_pkg::NUM_REQUESTORS-1:0] in_rd_en;
  logic [memory_request_pkg::NUM_REQUESTORS-1:0] in_valid;
  logic [memory_request_pkg::NUM_REQUESTORS-1:0] in_empty;
  logic [memory_request_pkg::NUM_REQUESTORS-1:0] in_full;
  logic [memory_request_pkg::NUM_REQUESTORS-1:0] in_prog_full;
  logic [memory_request_pkg::NUM_REQUESTORS-1:0] in_rst_busy;
  logic [memory_request_pkg::PAYLOAD_WIDTH-1:0]  in_dout [memory_request_pkg::NUM_REQUESTORS];

  // Arbiter
  logic [memory_request_pkg::NUM_REQUESTORS-1:0] arbiter_request;
  logic [memory_request_pkg::NUM_REQUESTORS-1:0] arbiter_grant;
  logic                                          arbiter_bus_valid;
  logic [memory_request_pkg::PAYLOAD_WIDTH-1:0]  arbiter_bus_payload;

  // Output FIFO ports
  logic                                         out_wr_en_reg;
  logic [memory_request_pkg::PAYLOAD_WIDTH-1:0] out_din_reg;
  logic                                         pop_reg;
  logic                                         out_rd_en;
  logic [memory_request_pkg::PAYLOAD_WIDTH-1:0] out_fifo_dout;
  logic                                         out_fifo_valid;
  logic                                         out_fifo_empty;
  logic                                         out_fifo_full;
  logic                                         out_fifo_prog_full;
  logic                                         out_fifo_rst_busy;

  // Any FIFO still leaving reset
  logic setup_int;

  // ---------------------------------------
  // Reset registering
  // ---------------------------------------
  always_ff @(posedge ap_clk) begin
    reset_local   <= areset_control;
    reset_fifo    <= areset_control;
    reset_arbiter <= areset_control;
  end

  // ---------------------------------------
  // Input registers
  // ---------------------------------------
  always_ff @(posedge ap_clk) begin
    if (reset_local) begin
      request_in_valid_reg <= '0;
    end else begin
      request_in_valid_reg <= request_in_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < memory_request_pkg::NUM_REQUESTORS; i++) begin
      request_in_payload_reg[i] <= request_in_payload[i];
    end
  end

  // ---------------------------------------
  // Per-requestor input FIFOs
  // ---------------------------------------
  for (genvar i = 0; i < memory_request_pkg::NUM_REQUESTORS; i++) begin : gen_in_fifo
    // Grant pops only a FIFO that holds data
    assign in_rd_en[i] = arbiter_grant[i] & ~in_empty[i];

    sync_fifo #(
      .DEPTH      (memory_request_pkg::REQUEST_FIFO_DEPTH),
      .PROG_THRESH(memory_request_pkg::REQUEST_PROG_THRESH)
    ) u_in_fifo (
      .ap_clk   (ap_clk),
      .reset    (reset_fifo),
      .din      (request_in_payload_reg[i]),
      .wr_en    (request_in_valid_reg[i]),
      .rd_en    (in_rd_en[i]),
      .dout     (in_dout[i]),
      .valid    (in_valid[i]),
      .empty    (in_empty[i]),
      .full     (in_full[i]),
      .prog_full(in_prog_full[i]),
      .rst_busy (in_rst_busy[i])
    );

    // Ready threshold must absorb every push still in flight
    assert property (@(posedge ap_clk) disable iff (reset_local)
      request_in_valid_reg[i] |-> !in_full[i])
      else $error("input FIFO %0d written while full", i);
  end

  // ---------------------------------------
  // Arbitration
  // ---------------------------------------

  // Hold off while the output FIFO is above its threshold
  assign arbiter_request = ~in_empty & {memory_request_pkg::NUM_REQUESTORS{~out_fifo_prog_full}};

  round_robin_arbiter u_arbiter (
    .ap_clk         (ap_clk),
    .reset          (reset_arbiter),
    .request        (arbiter_request),
    .grant          (arbiter_grant),
    .bus_valid      (in_valid),
    .bus_in         (in_dout),
    .bus_out_valid  (arbiter_bus_valid),
    .bus_out_payload(arbiter_bus_payload)
  );

  // Bus register into the output FIFO
  always_ff @(posedge ap_clk) begin
    if (reset_local) begin
      out_wr_en_reg <= 1'b0;
    end else begin
      out_wr_en_reg <= arbiter_bus_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    out_din_reg <= arbiter_bus_payload;
  end

  // ---------------------------------------
  // Output FIFO
  // ---------------------------------------
  always_ff @(posedge ap_clk) begin
    if (reset_local) begin
      pop_reg <= 1'b0;
    end else begin
      pop_reg <= pop_out;
    end
  end

  assign out_rd_en = pop_reg & ~out_fifo_empty;

  sync_fifo #(
    .DEPTH      (memory_request_pkg::OUT_FIFO_DEPTH),
    .PROG_THRESH(memory_request_pkg::OUT_PROG_THRESH)
  ) u_out_fifo (
    .ap_clk   (ap_clk),
    .reset    (reset_fifo),
    .din      (out_din_reg),
    .wr_en    (out_wr_en_reg),
    .rd_en    (out_rd_en),
    .dout     (out_fifo_dout),
    .valid    (out_fifo_valid),
    .empty    (out_fifo_empty),
    .full     (out_fifo_full),
    .prog_full(out_fifo_prog_full),
    .rst_busy (out_fifo_rst_busy)
  );

  // Arbiter hold-off keeps the pipeline tail inside the spare half
  assert property (@(posedge ap_clk) disable iff (reset_local)
    !out_fifo_full)
    else $error("output FIFO reached full");

  // ---------------------------------------
  // Outputs, ready and setup
  // ---------------------------------------
  assign setup_int = out_fifo_rst_busy | (|in_rst_busy);

  always_ff @(posedge ap_clk) begin
    if (reset_local) begin
      request_out_valid <= 1'b0;
      out_empty         <= 1'b1;
      out_prog_full     <= 1'b0;
      fifo_setup        <= 1'b1;
      requestor_ready   <= '0;
    end else begin
      request_out_valid <= out_fifo_valid;
      out_empty         <= out_fifo_empty;
      out_prog_full     <= out_fifo_prog_full;
      fifo_setup        <= setup_int;
      // Own FIFO and shared FIFO both need room, none while in setup
      requestor_ready   <= ~in_prog_full &
                           {memory_request_pkg::NUM_REQUESTORS{~out_fifo_prog_full & ~setup_int}};
    end
  end

  // Payload follows request_out_valid
  always_ff @(posedge ap_clk) begin
    request_out_payload <= out_fifo_dout;
  end

endmodule : memory_request_arbiter

//--- rtl/memory_request_pkg.sv
package memory_request_pkg;

  // ---------------------------------------
  // Requestor side
  // ---------------------------------------

  // Engines feeding the arbiter
  localparam int NUM_REQUESTORS = 4;

  // Index width for the requestor count
  localparam int REQUESTOR_ID_WIDTH = 2;

  // Opaque request word, never decoded here
  localparam int PAYLOAD_WIDTH = 64;

  // ---------------------------------------
  // FIFO sizing
  // ---------------------------------------

  // Per-requestor input FIFO
  localparam int REQUEST_FIFO_DEPTH = 16;

  // Leaves four slots for pushes still in flight after ready falls
  localparam int REQUEST_PROG_THRESH = 12;

  // Shared output FIFO
  localparam int OUT_FIFO_DEPTH = 32;

  // Half full, room for packets already in the arbiter pipeline
  localparam int OUT_PROG_THRESH = 16;

  // ---------------------------------------
  // FIFO reset
  // ---------------------------------------

  // Busy cycles after a FIFO reset falls
  localparam int FIFO_RESET_BUSY_CYCLES = 4;

endpackage : memory_request_pkg

//--- rtl/round_robin_arbiter.sv
`timescale 1ns/1ns

module round_robin_arbiter (
  input  logic                                         ap_clk,
  input  logic                                         reset,
  input  logic [memory_request_pkg::NUM_REQUESTORS-1:0] request,
  output logic [memory_request_pkg::NUM_REQUESTORS-1:0] grant,
  input  logic [memory_request_pkg::NUM_REQUESTORS-1:0] bus_valid,
  input  logic [memory_request_pkg::PAYLOAD_WIDTH-1:0]  bus_in [memory_request_pkg::NUM_REQUESTORS],
  output logic                                          bus_out_valid,
  output logic [memory_request_pkg::PAYLOAD_WIDTH-1:0]  bus_out_payload
);

  // ---------------------------------------
  // Grant generation
  // ---------------------------------------
  logic [memory_request_pkg::NUM_REQUESTORS-1:0]     masked_request;
  logic [memory_request_pkg::NUM_REQUESTORS-1:0]     next_grant;
  logic [memory_request_pkg::REQUESTOR_ID_WIDTH-1:0] last_ptr;
  logic [memory_request_pkg::REQUESTOR_ID_WIDTH-1:0] next_ptr;

  // Muxed bus before the output register
  logic [memory_request_pkg::PAYLOAD_WIDTH-1:0] mux_payload;

  // Current grant still sees its FIFO as non-empty this cycle
  assign masked_request = request & ~grant;

  // Search starts one past the last winner
  always_comb begin
    int  idx;
    logic found;
    next_grant = '0;
    next_ptr   = last_ptr;
    found      = 1'b0;
    for (int k = 1; k <= memory_request_pkg::NUM_REQUESTORS; k++) begin
      idx = (int'(last_ptr) + k) % memory_request_pkg::NUM_REQUESTORS;
      if (!found && masked_request[idx]) begin
        found           = 1'b1;
        next_grant[idx] = 1'b1;
        next_ptr        = idx[memory_request_pkg::REQUESTOR_ID_WIDTH-1:0];
      end
    end
  end

  // Pointer starts at the top so index 0 wins first
  always_ff @(posedge ap_clk) begin
    if (reset) begin
      grant    <= '0;
      last_ptr <= '1;
    end else begin
      grant <= next_grant;
      if (|next_grant) begin
        last_ptr <= next_ptr;
      end
    end
  end

  // ---------------------------------------
  // Bus multiplexer
  // ---------------------------------------

  // Only one FIFO answers per cycle, so priority order is irrelevant
  always_comb begin
    mux_payload = '0;
    for (int i = 0; i < memory_request_pkg::NUM_REQUESTORS; i++) begin
      if (bus_valid[i]) begin
        mux_payload = bus_in[i];
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (reset) begin
      bus_out_valid <= 1'b0;
    end else begin
      bus_out_valid <= |bus_valid;
    end
  end

  // Payload register, qualified by bus_out_valid
  always_ff @(posedge ap_clk) begin
    bus_out_payload <= mux_payload;
  end

  // Rotating search never picks two winners
  assert property (@(posedge ap_clk) disable iff (reset)
    $onehot0(grant))
    else $error("round_robin_arbiter grant not one-hot");

  // One pop per cycle upstream means one read valid per cycle here
  assert property (@(posedge ap_clk) disable iff (reset)
    $onehot0(bus_valid))
    else $error("round_robin_arbiter multiple bus_valid");

endmodule : round_robin_arbiter

//--- rtl/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
  parameter int DEPTH       = 16,
  parameter int PROG_THRESH = 12
) (
  input  logic                                         ap_clk,
  input  logic                                         reset,
  input  logic [memory_request_pkg::PAYLOAD_WIDTH-1:0] din,
  input  logic                                         wr_en,
  input  logic                                         rd_en,
  output logic [memory_request_pkg::PAYLOAD_WIDTH-1:0] dout,
  output logic                                         valid,
  output logic                                         empty,
  output logic                                         full,
  output logic                                         prog_full,
  output logic                                         rst_busy
);

  // Widths derived from the depth, DEPTH is a power of two
  localparam int ADDR_WIDTH  = $clog2(DEPTH);
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);
  localparam int BUSY_WIDTH  = $clog2(memory_request_pkg::FIFO_RESET_BUSY_CYCLES + 1);

  // ---------------------------------------
  // Storage and state
  // ---------------------------------------
  logic [memory_request_pkg::PAYLOAD_WIDTH-1:0] mem [DEPTH];

  logic [ADDR_WIDTH-1:0]  wr_ptr;
  logic [ADDR_WIDTH-1:0]  rd_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic [BUSY_WIDTH-1:0]  busy_count;

  // Accepted operations only
  logic wr_fire;
  logic rd_fire;

  // ---------------------------------------
  // Reset busy countdown
  // ---------------------------------------

  // Loaded while reset is high, runs down once reset falls
  always_ff @(posedge ap_clk) begin
    if (reset) begin
      busy_count <= BUSY_WIDTH'(memory_request_pkg::FIFO_RESET_BUSY_CYCLES);
    end else if (busy_count != '0) begin
      busy_count <= busy_count - BUSY_WIDTH'(1);
    end
  end

  assign rst_busy = (busy_count != '0);

  // Requests are dropped while busy or at the limits
  assign wr_fire = wr_en & ~full & ~rst_busy;
  assign rd_fire = rd_en & ~empty & ~rst_busy;

  // ---------------------------------------
  // Pointers and fill count
  // ---------------------------------------
  always_ff @(posedge ap_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap on their own width
      if (wr_fire) begin
        wr_ptr <= wr_ptr + ADDR_WIDTH'(1);
      end
      if (rd_fire) begin
        rd_ptr <= rd_ptr + ADDR_WIDTH'(1);
      end
      // Simultaneous push and pop leave the count alone
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + COUNT_WIDTH'(1);
        2'b01:   count <= count - COUNT_WIDTH'(1);
        default: count <= count;
      endcase
    end
  end

  // ---------------------------------------
  // Circular buffer
  // ---------------------------------------
  always_ff @(posedge ap_clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= din;
    end
  end

  // Read data lands one cycle after the accepted read
  always_ff @(posedge ap_clk) begin
    if (rd_fire) begin
      dout <= mem[rd_ptr];
    end
  end

  always_ff @(posedge ap_clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else begin
      valid <= rd_fire;
    end
  end

  // ---------------------------------------
  // Status flags
  // ---------------------------------------
  assign empty     = (count == '0);
  assign full      = (count == COUNT_WIDTH'(DEPTH));
  assign prog_full = (count >= COUNT_WIDTH'(PROG_THRESH));

  // Upstream must honour full, not rely on the drop
  assert property (@(posedge ap_clk) disable iff (reset)
    !(wr_en && full))
    else $error("sync_fifo write while full");

  // Readers gate rd_en with empty themselves
  assert property (@(posedge ap_clk) disable iff (reset)
    !(rd_en && empty))
    else $error("sync_fifo read while empty");

endmodule : sync_fifo

//--- tests/tb_memory_request_arbiter.sv
`timescale 1ns/1ns

module tb_memory_request_arbiter;

  localparam int NUM_REQ = memory_request_pkg::NUM_REQUESTORS;
  localparam int PW      = memory_request_pkg::PAYLOAD_WIDTH;
  localparam int IDW     = memory_request_pkg::REQUESTOR_ID_WIDTH;

  // Push modes per cycle
  localparam int MODE_IDLE   = 0;
  localparam int MODE_RANDOM = 1;
  localparam int MODE_FLOOD  = 2;

  // Run lengths and wait bounds in cycles
  localparam int SETUP_TIMEOUT     = memory_request_pkg::FIFO_RESET_BUSY_CYCLES + 8;
  localparam int FILL_TIMEOUT      = 200;
  localparam int DRAIN_TIMEOUT     = 1000;
  localparam int DRAIN_IDLE_CYCLES = 20;
  localparam int RANDOM_CYCLES     = 400;
  localparam int FAIR_CYCLES       = 400;
  localparam int STARVE_LIMIT      = 64;

  logic          ap_clk;
  logic          areset_control;
  logic [NUM_REQ-1:0] request_in_valid;
  logic [PW-1:0] request_in_payload [NUM_REQ];
  logic          pop_out;
  logic [NUM_REQ-1:0] requestor_ready;
  logic          request_out_valid;
  logic [PW-1:0] request_out_payload;
  logic          out_empty;
  logic          out_prog_full;
  logic          fifo_setup;

  // ---------------------------------------
  // Scoreboards and check enables
  // ---------------------------------------
  int push_count [NUM_REQ];
  int recv_count [NUM_REQ];
  int starve_count [NUM_REQ];
  int error_count;
  int timeout_count;
  logic [15:0] lfsr_state;
  logic [2:0]  reset_pipe;
  logic hold_check;
  logic drain_check;
  logic fair_check;

  // Id in the top bits and sequence in the low word
  logic [IDW-1:0] out_id;
  logic [31:0]    out_seq;
  assign out_id  = request_out_payload[PW-1 -: IDW];
  assign out_seq = request_out_payload[31:0];

  memory_request_arbiter dut0 (
    .ap_clk             (ap_clk),
    .areset_control     (areset_control),
    .request_in_valid   (request_in_valid),
    .request_in_payload (request_in_payload),
    .pop_out            (pop_out),
    .requestor_ready    (requestor_ready),
    .request_out_valid  (request_out_valid),
    .request_out_payload(request_out_payload),
    .out_empty          (out_empty),
    .out_prog_full      (out_prog_full),
    .fifo_setup         (fifo_setup)
  );

  // 20 ns period
  always #10 ap_clk = ~ap_clk;

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic take_random_bit(output logic bit_out);
    lfsr_state = lfsr_step(lfsr_state);
    bit_out    = lfsr_state[0];
  endtask

  function automatic logic [PW-1:0] build_payload(input int id, input int seq);
    logic [PW-1:0] word;
    word              = '0;
    word[PW-1 -: IDW] = id[IDW-1:0];
    word[31:0]        = seq;
    return word;
  endfunction

  // One falling edge of stimulus that pushes only where ready is high
  task automatic drive_cycle(input int mode, input logic pop_level);
    logic want;
    @(negedge ap_clk);
    pop_out = pop_level;
    for (int i = 0; i < NUM_REQ; i++) begin
      want = (mode == MODE_FLOOD);
      if (mode == MODE_RANDOM) begin
        take_random_bit(want);
      end
      request_in_valid[i] = want & requestor_ready[i];
      if (want && requestor_ready[i]) begin
        request_in_payload[i] = build_payload(i, push_count[i]);
        push_count[i]++;
      end
    end
  endtask

  task automatic wait_setup_done();
    int waited;
    waited = 0;
    while (fifo_setup && waited < SETUP_TIMEOUT) begin
      drive_cycle(MODE_IDLE, 1'b0);
      waited++;
    end
    if (fifo_setup) begin
      $display("Timeout: fifo_setup did not fall after reset");
      timeout_count++;
    end
  endtask

  // Pop held low while every requestor pushes on ready
  task automatic hold_and_fill();
    int waited;
    waited = 0;
    // Tail of earlier pops still reaches the outputs
    repeat (4) drive_cycle(MODE_FLOOD, 1'b0);
    @(posedge ap_clk);
    hold_check <= 1'b1;
    while (!(out_prog_full && requestor_ready == '0) && waited < FILL_TIMEOUT) begin
      drive_cycle(MODE_FLOOD, 1'b0);
      waited++;
    end
    if (!(out_prog_full && requestor_ready == '0)) begin
      $display("Timeout: output FIFO never reached its threshold with pop held low");
      timeout_count++;
    end
    // Pushes in flight land while ready is low
    repeat (20) drive_cycle(MODE_FLOOD, 1'b0);
    @(posedge ap_clk);
    hold_check <= 1'b0;
  endtask

  // Pop until the output stays empty and then compare counts
  task automatic drain_and_check();
    int idle;
    int waited;
    idle   = 0;
    waited = 0;
    while (idle < DRAIN_IDLE_CYCLES && waited < DRAIN_TIMEOUT) begin
      drive_cycle(MODE_IDLE, 1'b1);
      idle = out_empty ? idle + 1 : 0;
      waited++;
    end
    if (idle < DRAIN_IDLE_CYCLES) begin
      $display("Timeout: output FIFO did not drain");
      timeout_count++;
    end else begin
      @(posedge ap_clk);
      drain_check <= 1'b1;
      @(posedge ap_clk);
      drain_check <= 1'b0;
    end
  endtask

  // ---------------------------------------
  // Receive side bookkeeping
  // ---------------------------------------
  always @(posedge ap_clk) begin
    reset_pipe <= {reset_pipe[1:0], areset_control};
    for (int i = 0; i < NUM_REQ; i++) begin
      if (areset_control) begin
        recv_count[i] <= 0;
      end else if (request_out_valid && int'(out_id) == i) begin
        recv_count[i] <= recv_count[i] + 1;
      end
      // Gap since the last packet of a requestor with work pending
      if (!fair_check || recv_count[i] == push_count[i] ||
          (request_out_valid && int'(out_id) == i)) begin
        starve_count[i] <= 0;
      end else begin
        starve_count[i] <= starve_count[i] + 1;
      end
    end
  end

  // ---------------------------------------
  // Checks sampled on the falling edge
  // ---------------------------------------
  assert property (@(negedge ap_clk) reset_pipe[2] |-> fifo_setup)
    else begin
      error_count++;
      $display("Fail %0t: fifo_setup low during reset", $time);
    end

  assert property (@(negedge ap_clk) fifo_setup |-> !request_out_valid && requestor_ready == '0)
    else begin
      error_count++;
      $display("Fail %0t: output activity while fifo_setup is high", $time);
    end

  // Output FIFO flags hold their reset values until setup ends
  assert property (@(negedge ap_clk) fifo_setup |-> out_empty && !out_prog_full)
    else begin
      error_count++;
      $display("Fail %0t: out_empty %b out_prog_full %b while fifo_setup is high",
               $time, out_empty, out_prog_full);
    end

  assert property (@(negedge ap_clk) hold_check |-> !request_out_valid)
    else begin
      error_count++;
      $display("Fail %0t: request_out_valid with pop_out held low", $time);
    end

  // Next sequence number per requestor with the middle bits untouched
  assert property (@(negedge ap_clk) request_out_valid |->
    out_seq == recv_count[out_id] && request_out_payload[PW-IDW-1:32] == '0)
    else begin
      error_count++;
      $display("Fail %0t: requestor %0d payload %h, expected seq %0d",
               $time, out_id, request_out_payload, recv_count[out_id]);
    end

  for (genvar g = 0; g < NUM_REQ; g++) begin : gen_requestor_checks
    assert property (@(negedge ap_clk) drain_check |-> recv_count[g] == push_count[g])
      else begin
        error_count++;
        $display("Fail %0t: requestor %0d delivered %0d of %0d pushed",
                 $time, g, recv_count[g], push_count[g]);
      end

    assert property (@(negedge ap_clk) starve_count[g] < STARVE_LIMIT)
      else begin
        error_count++;
        $display("Requestor %0d got no packet out for %0d cycles", g, starve_count[g]);
      end
  end

  initial begin
    logic pop_a;
    logic pop_b;
    ap_clk           = 1'b0;
    areset_control   = 1'b1;
    request_in_valid = '0;
    pop_out          = 1'b0;
    for (int i = 0; i < NUM_REQ; i++) begin
      request_in_payload[i] = '0;
      push_count[i]         = 0;
    end
    lfsr_state    = 16'd26;
    error_count   = 0;
    timeout_count = 0;
    hold_check    = 1'b0;
    drain_check   = 1'b0;
    fair_check    = 1'b0;

    repeat (5) @(negedge ap_clk);
    areset_control = 1'b0;
    wait_setup_done();

    if (timeout_count == 0) begin
      // Mixed traffic with pop high three cycles in four
      repeat (RANDOM_CYCLES) begin
        take_random_bit(pop_a);
        take_random_bit(pop_b);
        drive_cycle(MODE_RANDOM, pop_a | pop_b);
      end
      hold_and_fill();
    end
    if (timeout_count == 0) begin
      drain_and_check();
    end
    if (timeout_count == 0) begin
      // Saturated inputs with the memory side always popping
      @(posedge ap_clk);
      fair_check <= 1'b1;
      repeat (FAIR_CYCLES) drive_cycle(MODE_FLOOD, 1'b1);
      @(posedge ap_clk);
      fair_check <= 1'b0;
      drain_and_check();
    end

    $display("Checks done: %0d errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule : tb_memory_request_arbiter
